// ==== lsq.f ====
logic/lsq_cfg_pkg.sv
logic/lsq_types_pkg.sv
logic/mem_req_if.sv
logic/ring_ptr.sv
logic/store_queue.sv
logic/load_queue.sv
logic/mem_port_fsm.sv
logic/lsq_top.sv
tests/wb_mem_model.sv
tests/lsq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the load-store unit testbench with Verilator, run it and look for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f lsq.f --top-module lsq_tb -o lsq_sim

out="$(./obj_dir/lsq_sim)"
echo "$out"

if grep -qx "ALL CHECKS PASSED" <<< "$out"; then
	exit 0
else
	exit 1
fi

// ==== tests/lsq_tb.sv ====
// Table-driven testbench for the load-store unit, playing dispatch, scheduler and branch unit.
`timescale 1ns/1ps

module lsq_tb;

	typedef enum {T_BEGIN, T_DISP, T_EXEC, T_RETIRE, T_LOAD, T_SQUASH, T_RESOLVE,
		T_ISS, T_FULL, T_DRAIN} op_e;

	// n is the store ordinal of an exec or the tag of a load
	// m is the branch mask of a load, a squash or a resolve
	// a squash drops its last n stores
	typedef struct {
		op_e         op;
		string       name;
		logic [31:0] a;
		logic [31:0] d;
		int          n;
		logic [3:0]  m;
		int          e;
	} step_t;

	logic        clk;
	logic        rst;
	logic        dp_st_i, st_vld_i, st_retire_i;
	logic [2:0]  st_idx_i;
	logic [31:0] st_addr_i, st_data_i;
	logic [3:0]  sq_tail_o, rs_ld_pos_i, ld_sq_pos_i, sq_tail_restore_i;
	logic        sq_full_o, ld_iss_ok_o, ld_vld_i, ld_done_o;
	logic [31:0] ld_addr_i, ld_data_o;
	logic [5:0]  ld_tag_i, ld_tag_o;
	logic [3:0]  ld_br_mask_i, br_fix_mask_i;
	logic        br_squash_i, br_correct_i;
	logic        wb_cyc, wb_stb, wb_we, wb_ack;
	logic [31:0] wb_adr, wb_dat_w, wb_dat_r;

	step_t       tbl[$];
	int          limit = 100000;
	int          cycles = 0;
	int          errors = 0;
	int          checks = 0;
	int          test_err = 0;
	string       cur_name = "";

	// software store list by dispatch ordinal
	logic [3:0]  st_pos [64];
	logic [31:0] st_addr [64];
	logic [31:0] st_data [64];
	bit          st_exec [64];
	bit          st_live [64];
	bit          st_ret [64];
	int          n_disp = 0;
	int          ret_ord = 0;
	logic [3:0]  tail_m = '0;

	// expected loads by tag
	bit          pend [64];
	bit          is_miss [64];
	logic [31:0] exp_d [64];
	logic [3:0]  ld_mask [64];
	int          npend = 0;
	int          miss_q[$];
	logic [31:0] wr_addr_q[$];
	logic [31:0] wr_data_q[$];
	logic [31:0] ref_mem [64];
	int          mon_tag;

	lsq_top dut_i (
		.clk (clk), .rst (rst),
		.dp_st_i (dp_st_i), .st_vld_i (st_vld_i), .st_idx_i (st_idx_i),
		.st_addr_i (st_addr_i), .st_data_i (st_data_i), .st_retire_i (st_retire_i),
		.sq_tail_o (sq_tail_o), .sq_full_o (sq_full_o),
		.rs_ld_pos_i (rs_ld_pos_i), .ld_iss_ok_o (ld_iss_ok_o), .ld_vld_i (ld_vld_i),
		.ld_addr_i (ld_addr_i), .ld_sq_pos_i (ld_sq_pos_i), .ld_tag_i (ld_tag_i),
		.ld_br_mask_i (ld_br_mask_i), .ld_done_o (ld_done_o), .ld_data_o (ld_data_o),
		.ld_tag_o (ld_tag_o),
		.br_squash_i (br_squash_i), .br_correct_i (br_correct_i),
		.br_fix_mask_i (br_fix_mask_i), .sq_tail_restore_i (sq_tail_restore_i),
		.wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
		.wb_dat_o (wb_dat_w), .wb_dat_i (wb_dat_r), .wb_ack_i (wb_ack)
	);

	wb_mem_model mem_i (
		.clk (clk), .rst (rst),
		.wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return 32'hc0de_0000 ^ (addr * 32'h0001_0001);
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
		end
	endtask

	task automatic add_step(input op_e op, input string name, input logic [31:0] a,
		input logic [31:0] d, input int n, input logic [3:0] m, input int e);
		step_t s;
		s.op = op;
		s.name = name;
		s.a = a;
		s.d = d;
		s.n = n;
		s.m = m;
		s.e = e;
		tbl.push_back(s);
	endtask

	task automatic dispatch_store();
		check_val("sq_tail before dispatch", 32'(tail_m), 32'(sq_tail_o));
		st_pos[n_disp] = tail_m;
		st_live[n_disp] = 1'b1;
		n_disp++;
		tail_m = tail_m + 1'b1;
		rs_ld_pos_i = tail_m;
		ld_sq_pos_i = tail_m;
		dp_st_i = 1'b1;
		step();
		dp_st_i = 1'b0;
	endtask

	task automatic execute_store(input int ord, input logic [31:0] addr, input logic [31:0] data);
		st_exec[ord] = 1'b1;
		st_addr[ord] = addr;
		st_data[ord] = data;
		st_vld_i = 1'b1;
		st_idx_i = st_pos[ord][2:0];
		st_addr_i = addr;
		st_data_i = data;
		step();
		st_vld_i = 1'b0;
	endtask

	task automatic retire_store();
		while (!st_live[ret_ord])
			ret_ord++;
		st_ret[ret_ord] = 1'b1;
		ref_mem[st_addr[ret_ord][7:2]] = st_data[ret_ord];
		wr_addr_q.push_back(st_addr[ret_ord]);
		wr_data_q.push_back(st_data[ret_ord]);
		ret_ord++;
		st_retire_i = 1'b1;
		step();
		st_retire_i = 1'b0;
	endtask

	task automatic issue_load(input logic [31:0] addr, input int tag, input logic [3:0] mask);
		int hit;
		bit fwd;
		hit = -1;
		// youngest older executed store with the same word
		for (int k = n_disp - 1; k >= 0 && hit < 0; k--) begin
			if (st_live[k] && st_exec[k] && st_addr[k] == addr)
				hit = k;
		end
		fwd = (hit >= 0) && !st_ret[hit];
		while (!ld_iss_ok_o)
			step();
		pend[tag] = 1'b1;
		is_miss[tag] = !fwd;
		exp_d[tag] = (hit >= 0) ? st_data[hit] : ref_mem[addr[7:2]];
		ld_mask[tag] = mask;
		npend++;
		if (!fwd)
			miss_q.push_back(tag);
		ld_vld_i = 1'b1;
		ld_addr_i = addr;
		ld_tag_i = 6'(tag);
		ld_br_mask_i = mask;
		#10;
		if (fwd) begin
			checks++;
			if (!(ld_done_o && ld_tag_o == 6'(tag))) begin
				errors++;
				$display("test %s: load tag %0d was not forwarded in its issue cycle",
					cur_name, tag);
			end
		end
		step();
		ld_vld_i = 1'b0;
	endtask

	task automatic squash_branch(input logic [3:0] fix, input int cnt);
		logic [3:0] restore;
		restore = tail_m - 4'(cnt);
		for (int k = n_disp - cnt; k < n_disp; k++)
			st_live[k] = 1'b0;
		for (int t = 0; t < 64; t++) begin
			if (pend[t] && is_miss[t] && |(ld_mask[t] & fix)) begin
				pend[t] = 1'b0;
				npend--;
				for (int j = miss_q.size() - 1; j >= 0; j--)
					if (miss_q[j] == t)
						miss_q.delete(j);
			end
		end
		tail_m = restore;
		rs_ld_pos_i = restore;
		ld_sq_pos_i = restore;
		br_squash_i = 1'b1;
		br_fix_mask_i = fix;
		sq_tail_restore_i = restore;
		step();
		br_squash_i = 1'b0;
		check_val("sq_tail after squash", 32'(restore), 32'(sq_tail_o));
	endtask

	task automatic resolve_branch(input logic [3:0] fix);
		for (int t = 0; t < 64; t++)
			ld_mask[t] = ld_mask[t] & ~fix;
		br_correct_i = 1'b1;
		br_fix_mask_i = fix;
		step();
		br_correct_i = 1'b0;
	endtask

	task automatic wait_idle();
		while (npend > 0 || wr_addr_q.size() > 0 || wb_cyc)
			step();
		// let freed queue heads settle
		step();
		step();
	endtask

	task automatic end_test();
		if (cur_name != "") begin
			if (errors == test_err)
				$display("test %s: ok", cur_name);
			else
				$display("test %s: %0d errors", cur_name, errors - test_err);
		end
	endtask

	task automatic build_table();
		add_step(T_BEGIN, "forward_youngest", 0, 0, 0, 0, 0);
		add_step(T_DISP, "", 0, 0, 0, 0, 0);
		add_step(T_DISP, "", 0, 0, 0, 0, 0);
		add_step(T_EXEC, "", 32'h10, 32'h1111_0000, 0, 0, 0);
		add_step(T_EXEC, "", 32'h10, 32'h2222_0000, 1, 0, 0);
		add_step(T_LOAD, "", 32'h10, 0, 1, 4'b0000, 0);
		add_step(T_LOAD, "", 32'h14, 0, 2, 4'b0000, 0);
		add_step(T_RETIRE, "", 0, 0, 0, 0, 0);
		add_step(T_RETIRE, "", 0, 0, 0, 0, 0);
		add_step(T_DRAIN, "", 0, 0, 0, 0, 0);
		add_step(T_BEGIN, "age_gating", 0, 0, 0, 0, 0);
		add_step(T_DISP, "", 0, 0, 0, 0, 0);
		add_step(T_ISS, "", 0, 0, 0, 0, 0);
		add_step(T_EXEC, "", 32'h20, 32'h3333_0000, 2, 0, 0);
		add_step(T_ISS, "", 0, 0, 0, 0, 1);
		add_step(T_RETIRE, "", 0, 0, 0, 0, 0);
		add_step(T_DRAIN, "", 0, 0, 0, 0, 0);
		add_step(T_BEGIN, "store_drain", 0, 0, 0, 0, 0);
		for (int k = 0; k < 3; k++)
			add_step(T_DISP, "", 0, 0, 0, 0, 0);
		add_step(T_EXEC, "", 32'h30, 32'haaaa_0003, 3, 0, 0);
		add_step(T_EXEC, "", 32'h34, 32'hbbbb_0004, 4, 0, 0);
		add_step(T_EXEC, "", 32'h30, 32'hcccc_0005, 5, 0, 0);
		for (int k = 0; k < 3; k++)
			add_step(T_RETIRE, "", 0, 0, 0, 0, 0);
		add_step(T_DRAIN, "", 0, 0, 0, 0, 0);
		add_step(T_LOAD, "", 32'h30, 0, 3, 4'b0000, 0);
		add_step(T_LOAD, "", 32'h34, 0, 4, 4'b0000, 0);
		add_step(T_DRAIN, "", 0, 0, 0, 0, 0);
		add_step(T_BEGIN, "miss_order", 0, 0, 0, 0, 0);
		for (int k = 0; k < 4; k++)
			add_step(T_LOAD, "", 32'h40 + 32'(4 * k), 0, 5 + k, 4'b0000, 0);
		add_step(T_DRAIN, "", 0, 0, 0, 0, 0);
		add_step(T_BEGIN, "squash", 0, 0, 0, 0, 0);
		for (int k = 0; k < 3; k++)
			add_step(T_DISP, "", 0, 0, 0, 0, 0);
		for (int k = 0; k < 3; k++)
			add_step(T_EXEC, "", 32'h60 + 32'(4 * k), 32'hdddd_0000 + 32'(k), 6 + k, 0, 0);
		add_step(T_RETIRE, "", 0, 0, 0, 0, 0);
		add_step(T_RETIRE, "", 0, 0, 0, 0, 0);
		add_step(T_LOAD, "", 32'h50, 0, 9, 4'b0001, 0);
		add_step(T_LOAD, "", 32'h54, 0, 10, 4'b0010, 0);
		add_step(T_SQUASH, "", 0, 0, 1, 4'b0001, 0);
		add_step(T_RESOLVE, "", 0, 0, 0, 4'b0010, 0);
		// the resolved bit no longer ties load 10 to its branch
		add_step(T_SQUASH, "", 0, 0, 0, 4'b0010, 0);
		add_step(T_DRAIN, "", 0, 0, 0, 0, 0);
		add_step(T_LOAD, "", 32'h68, 0, 11, 4'b0000, 0);
		add_step(T_DRAIN, "", 0, 0, 0, 0, 0);
		add_step(T_BEGIN, "full_flags", 0, 0, 0, 0, 0);
		for (int k = 0; k < 8; k++)
			add_step(T_DISP, "", 0, 0, 0, 0, 0);
		add_step(T_FULL, "", 0, 0, 0, 0, 1);
		// the squashed ordinal 8 still counts and these are 9 to 16
		for (int k = 0; k < 8; k++)
			add_step(T_EXEC, "", 32'h80 + 32'(4 * k), 32'heeee_0000 + 32'(k), 9 + k, 0, 0);
		for (int k = 0; k < 4; k++)
			add_step(T_RETIRE, "", 0, 0, 0, 0, 0);
		for (int k = 0; k < 4; k++)
			add_step(T_LOAD, "", 32'hc0 + 32'(4 * k), 0, 12 + k, 4'b0000, 0);
		add_step(T_ISS, "", 0, 0, 0, 0, 0);
		for (int k = 0; k < 4; k++)
			add_step(T_RETIRE, "", 0, 0, 0, 0, 0);
		add_step(T_DRAIN, "", 0, 0, 0, 0, 0);
		add_step(T_FULL, "", 0, 0, 0, 0, 0);
		add_step(T_ISS, "", 0, 0, 0, 0, 1);
	endtask

	// ************************************************************
	// scoreboard on completions and bus writes
	// ************************************************************

	always @(posedge clk) begin
		if (!rst) begin
			if (ld_done_o) begin
				mon_tag = int'(ld_tag_o);
				if (!pend[mon_tag]) begin
					errors++;
					$display("test %s: load tag %0d completed with no live load pending",
						cur_name, mon_tag);
				end else begin
					check_val($sformatf("load tag %0d data", mon_tag), exp_d[mon_tag], ld_data_o);
					if (is_miss[mon_tag]) begin
						checks++;
						if (miss_q.size() == 0 || miss_q[0] != mon_tag) begin
							errors++;
							$display("test %s: load tag %0d completed out of allocation order",
								cur_name, mon_tag);
						end else begin
							void'(miss_q.pop_front());
						end
					end
					pend[mon_tag] = 1'b0;
					npend--;
				end
			end
			if (wb_cyc && wb_stb && wb_ack && wb_we) begin
				if (wr_addr_q.size() == 0) begin
					errors++;
					$display("test %s: unexpected memory write to %h", cur_name, wb_adr);
				end else begin
					check_val("drain address", wr_addr_q.pop_front(), wb_adr);
					check_val("drain data", wr_data_q.pop_front(), wb_dat_w);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: run exceeded %0d cycles", limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		dp_st_i = 1'b0;
		st_vld_i = 1'b0;
		st_idx_i = '0;
		st_addr_i = '0;
		st_data_i = '0;
		st_retire_i = 1'b0;
		rs_ld_pos_i = '0;
		ld_sq_pos_i = '0;
		ld_vld_i = 1'b0;
		ld_addr_i = '0;
		ld_tag_i = '0;
		ld_br_mask_i = '0;
		br_squash_i = 1'b0;
		br_correct_i = 1'b0;
		br_fix_mask_i = '0;
		sq_tail_restore_i = '0;
		for (int i = 0; i < 64; i++) begin
			ref_mem[i] = fill_word(32'(i * 4));
			pend[i] = 1'b0;
			st_live[i] = 1'b0;
			st_exec[i] = 1'b0;
			st_ret[i] = 1'b0;
		end
		build_table();
		limit = tbl.size() * 40;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		step();
		foreach (tbl[i]) begin
			case (tbl[i].op)
				T_BEGIN: begin
					end_test();
					cur_name = tbl[i].name;
					test_err = errors;
				end
				T_DISP: dispatch_store();
				T_EXEC: execute_store(tbl[i].n, tbl[i].a, tbl[i].d);
				T_RETIRE: retire_store();
				T_LOAD: issue_load(tbl[i].a, tbl[i].n, tbl[i].m);
				T_SQUASH: squash_branch(tbl[i].m, tbl[i].n);
				T_RESOLVE: resolve_branch(tbl[i].m);
				T_ISS: check_val("ld_iss_ok", 32'(tbl[i].e), 32'(ld_iss_ok_o));
				T_FULL: check_val("sq_full", 32'(tbl[i].e), 32'(sq_full_o));
				T_DRAIN: wait_idle();
				default: ;
			endcase
		end
		end_test();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== tests/wb_mem_model.sv ====
// Word-wide Wishbone classic slave memory for the testbench, acking after a pseudo-random delay.
`timescale 1ns/1ps

module wb_mem_model (
	input  logic        clk,
	input  logic        rst,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [31:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o
);

	logic [31:0] mem [64];
	logic [5:0]  lfsr;
	logic [1:0]  cnt;
	logic        busy;

	// taps x^6 and x^5 with one step per bit
	function automatic logic [5:0] lfsr_step(input logic [5:0] s);
		return {s[4:0], s[5] ^ s[4]};
	endfunction

	initial begin
		for (int i = 0; i < 64; i++)
			mem[i] = 32'hc0de_0000 ^ (32'(i * 4) * 32'h0001_0001);
	end

	always @(posedge clk) begin
		logic [5:0] s1;
		logic [5:0] s2;
		if (rst) begin
			wb_ack_o <= 1'b0;
			busy <= 1'b0;
			cnt <= '0;
			lfsr <= 6'd63;
		end else if (wb_ack_o) begin
			wb_ack_o <= 1'b0;
		end else if (busy) begin
			if (cnt == 0) begin
				wb_ack_o <= 1'b1;
				busy <= 1'b0;
				wb_dat_o <= mem[wb_adr_i[7:2]];
				if (wb_we_i)
					mem[wb_adr_i[7:2]] <= wb_dat_i;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end else if (wb_cyc_i && wb_stb_i) begin
			// two bits give 1 to 4 wait cycles
			s1 = lfsr_step(lfsr);
			s2 = lfsr_step(s1);
			cnt <= {s1[0], s2[0]};
			lfsr <= s2;
			busy <= 1'b1;
		end
	end

endmodule

// ==== logic/lsq_top.sv ====
// Load-store unit top level joining both queues and the memory port behind plain ports.
`timescale 1ns/1ps

module lsq_top #(
	parameter int SQ_DEPTH = lsq_cfg_pkg::SQ_DEPTH_DEF,
	parameter int LQ_DEPTH = lsq_cfg_pkg::LQ_DEPTH_DEF,
	localparam int SQ_IDX_W = $clog2(SQ_DEPTH)
) (
	input  logic                           clk,
	input  logic                           rst,

	// store side
	input  logic                           dp_st_i,
	input  logic                           st_vld_i,
	input  logic [SQ_IDX_W-1:0]            st_idx_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0] st_addr_i,
	input  logic [lsq_cfg_pkg::DATA_W-1:0] st_data_i,
	input  logic                           st_retire_i,
	output logic [SQ_IDX_W:0]              sq_tail_o,
	output logic                           sq_full_o,

	// load side
	input  logic [SQ_IDX_W:0]              rs_ld_pos_i,
	output logic                           ld_iss_ok_o,
	input  logic                           ld_vld_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0] ld_addr_i,
	input  logic [SQ_IDX_W:0]              ld_sq_pos_i,
	input  logic [lsq_cfg_pkg::TAG_W-1:0]  ld_tag_i,
	input  logic [lsq_cfg_pkg::BR_W-1:0]   ld_br_mask_i,
	output logic                           ld_done_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0] ld_data_o,
	output logic [lsq_cfg_pkg::TAG_W-1:0]  ld_tag_o,

	// branch side
	input  logic                           br_squash_i,
	input  logic                           br_correct_i,
	input  logic [lsq_cfg_pkg::BR_W-1:0]   br_fix_mask_i,
	input  logic [SQ_IDX_W:0]              sq_tail_restore_i,

	// Wishbone classic master
	output logic                           wb_cyc_o,
	output logic                           wb_stb_o,
	output logic                           wb_we_o,
	output logic [lsq_cfg_pkg::ADDR_W-1:0] wb_adr_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0] wb_dat_o,
	input  logic [lsq_cfg_pkg::DATA_W-1:0] wb_dat_i,
	input  logic                           wb_ack_i
);

	logic                           fwd_vld;
	logic [lsq_cfg_pkg::DATA_W-1:0] fwd_data;
	logic                           fwd_hit;
	logic                           ld_miss;
	logic                           age_ok;
	logic                           lq_full;
	logic                           q_done;
	logic [lsq_cfg_pkg::DATA_W-1:0] q_data;
	logic [lsq_cfg_pkg::TAG_W-1:0]  q_tag;

	mem_req_if sq_mem ();
	mem_req_if lq_mem ();

	store_queue #(
		.SQ_DEPTH(SQ_DEPTH)
	) sq_i (
		.clk               (clk),
		.rst               (rst),
		.dp_st_i           (dp_st_i),
		.st_vld_i          (st_vld_i),
		.st_idx_i          (st_idx_i),
		.st_addr_i         (st_addr_i),
		.st_data_i         (st_data_i),
		.st_retire_i       (st_retire_i),
		.br_squash_i       (br_squash_i),
		.sq_tail_restore_i (sq_tail_restore_i),
		.rs_ld_pos_i       (rs_ld_pos_i),
		.ld_sq_pos_i       (ld_sq_pos_i),
		.ld_addr_i         (ld_addr_i),
		.fwd_vld_o         (fwd_vld),
		.fwd_data_o        (fwd_data),
		.ld_iss_ok_o       (age_ok),
		.sq_tail_o         (sq_tail_o),
		.sq_full_o         (sq_full_o),
		.mem               (sq_mem.requester)
	);

	load_queue #(
		.LQ_DEPTH(LQ_DEPTH)
	) lq_i (
		.clk           (clk),
		.rst           (rst),
		.miss_i        (ld_miss),
		.ld_addr_i     (ld_addr_i),
		.ld_tag_i      (ld_tag_i),
		.ld_br_mask_i  (ld_br_mask_i),
		.fwd_busy_i    (fwd_hit),
		.br_squash_i   (br_squash_i),
		.br_correct_i  (br_correct_i),
		.br_fix_mask_i (br_fix_mask_i),
		.lq_full_o     (lq_full),
		.q_done_o      (q_done),
		.q_data_o      (q_data),
		.q_tag_o       (q_tag),
		.mem           (lq_mem.requester)
	);

	mem_port_fsm port_i (
		.clk      (clk),
		.rst      (rst),
		.sq_mem   (sq_mem.server),
		.lq_mem   (lq_mem.server),
		.wb_cyc_o (wb_cyc_o),
		.wb_stb_o (wb_stb_o),
		.wb_we_o  (wb_we_o),
		.wb_adr_o (wb_adr_o),
		.wb_dat_o (wb_dat_o),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i)
	);

	// ************************************************************
	// result merge
	// ************************************************************

	// a forwarded load owns the result bus, the queue head waits
	assign fwd_hit = ld_vld_i && fwd_vld;
	assign ld_miss = ld_vld_i && !fwd_vld;
	assign ld_done_o = fwd_hit || q_done;
	assign ld_data_o = fwd_hit ? fwd_data : q_data;
	assign ld_tag_o = fwd_hit ? ld_tag_i : q_tag;

	assign ld_iss_ok_o = age_ok && !lq_full;

endmodule

// ==== logic/mem_port_fsm.sv ====
// Arbiter putting store drains and load misses onto one Wishbone classic master port.
`timescale 1ns/1ps

module mem_port_fsm (
	input  logic                           clk,
	input  logic                           rst,
	mem_req_if.server                      sq_mem,
	mem_req_if.server                      lq_mem,
	output logic                           wb_cyc_o,
	output logic                           wb_stb_o,
	output logic                           wb_we_o,
	output logic [lsq_cfg_pkg::ADDR_W-1:0] wb_adr_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0] wb_dat_o,
	input  logic [lsq_cfg_pkg::DATA_W-1:0] wb_dat_i,
	input  logic                           wb_ack_i
);

	typedef enum logic [1:0] {
		IDLE,
		STORE,
		LOAD
	} state_e;

	state_e state;
	state_e state_nxt;

	always_comb begin
		state_nxt = state;
		sq_mem.grant = 1'b0;
		lq_mem.grant = 1'b0;
		case (state)
			IDLE: begin
				// drain beats miss
				if (sq_mem.req) begin
					sq_mem.grant = 1'b1;
					state_nxt = STORE;
				end else if (lq_mem.req) begin
					lq_mem.grant = 1'b1;
					state_nxt = LOAD;
				end
			end
			STORE, LOAD: begin
				if (wb_ack_i)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// owner holds its request fields until done, so the bus follows them
	assign wb_cyc_o = (state != IDLE);
	assign wb_stb_o = (state != IDLE);
	assign wb_we_o = (state == STORE) ? (sq_mem.op == lsq_types_pkg::MEM_WRITE) :
		(lq_mem.op == lsq_types_pkg::MEM_WRITE);
	assign wb_adr_o = (state == STORE) ? sq_mem.addr : lq_mem.addr;
	assign wb_dat_o = (state == STORE) ? sq_mem.wdata : lq_mem.wdata;

	assign sq_mem.done = (state == STORE) && wb_ack_i;
	assign lq_mem.done = (state == LOAD) && wb_ack_i;
	assign sq_mem.rdata = wb_dat_i;
	assign lq_mem.rdata = wb_dat_i;

	a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
		wb_stb_o |-> wb_cyc_o);

	// a classic cycle keeps its address until the slave acks
	a_stb_hold: assert property (@(posedge clk) disable iff (rst)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule

// ==== logic/load_queue.sv ====
// Load queue for loads without a forwarding store, reading memory and completing in order.
`timescale 1ns/1ps

module load_queue #(
	parameter int LQ_DEPTH = lsq_cfg_pkg::LQ_DEPTH_DEF,
	localparam int IDX_W = $clog2(LQ_DEPTH)
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           miss_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0] ld_addr_i,
	input  logic [lsq_cfg_pkg::TAG_W-1:0]  ld_tag_i,
	input  logic [lsq_cfg_pkg::BR_W-1:0]   ld_br_mask_i,
	input  logic                           fwd_busy_i,
	input  logic                           br_squash_i,
	input  logic                           br_correct_i,
	input  logic [lsq_cfg_pkg::BR_W-1:0]   br_fix_mask_i,
	output logic                           lq_full_o,
	output logic                           q_done_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0] q_data_o,
	output logic [lsq_cfg_pkg::TAG_W-1:0]  q_tag_o,
	mem_req_if.requester                   mem
);

	lsq_types_pkg::lq_entry_t ent_q [LQ_DEPTH];

	logic [IDX_W:0]   head;
	logic [IDX_W:0]   tail;
	logic [IDX_W-1:0] head_idx;
	logic [IDX_W-1:0] tail_idx;
	logic [IDX_W-1:0] rd_idx_q;
	logic [IDX_W-1:0] pick_idx;
	logic             pick_vld;
	logic             rd_req_q;
	logic             empty;
	logic             head_busy;
	logic             head_free;

	ring_ptr #(
		.DEPTH(LQ_DEPTH)
	) ptr_i (
		.clk           (clk),
		.rst           (rst),
		.alloc_i       (miss_i),
		.free_i        (head_free),
		.restore_i     (1'b0),
		.restore_ptr_i ('0),
		.head_o        (head),
		.tail_o        (tail),
		.full_o        (lq_full_o),
		.empty_o       (empty)
	);

	assign head_idx = head[IDX_W-1:0];
	assign tail_idx = tail[IDX_W-1:0];

	// ************************************************************
	// completion at the head
	// ************************************************************

	// a squashed head still on the bus must wait for its done
	assign head_busy = rd_req_q && (rd_idx_q == head_idx);
	assign q_done_o = !empty && ent_q[head_idx].vld && ent_q[head_idx].filled && !fwd_busy_i;
	assign head_free = q_done_o || (!empty && !ent_q[head_idx].vld && !head_busy);
	assign q_data_o = ent_q[head_idx].data;
	assign q_tag_o = ent_q[head_idx].tag;

	// oldest live entry still without data
	always_comb begin
		logic [IDX_W:0]   cnt;
		logic [IDX_W-1:0] idx;
		cnt = tail - head;
		pick_vld = 1'b0;
		pick_idx = '0;
		for (int k = LQ_DEPTH - 1; k >= 0; k--) begin
			idx = head_idx + IDX_W'(k);
			if (k < cnt && ent_q[idx].vld && !ent_q[idx].filled) begin
				pick_vld = 1'b1;
				pick_idx = idx;
			end
		end
	end

	// ************************************************************
	// entry state
	// ************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_req_q <= 1'b0;
			rd_idx_q <= '0;
			for (int i = 0; i < LQ_DEPTH; i++) begin
				ent_q[i].vld <= 1'b0;
				ent_q[i].filled <= 1'b0;
			end
		end else begin
			if (mem.done) begin
				rd_req_q <= 1'b0;
				ent_q[rd_idx_q].filled <= 1'b1;
				ent_q[rd_idx_q].data <= mem.rdata;
			end else if (!rd_req_q && pick_vld) begin
				rd_req_q <= 1'b1;
				rd_idx_q <= pick_idx;
			end
			for (int i = 0; i < LQ_DEPTH; i++) begin
				if (br_squash_i && |(ent_q[i].br_mask & br_fix_mask_i))
					ent_q[i].vld <= 1'b0;
				else if (br_correct_i)
					ent_q[i].br_mask <= ent_q[i].br_mask & ~br_fix_mask_i;
			end
			// branch events in the allocation cycle apply to the new entry too
			if (miss_i) begin
				ent_q[tail_idx].vld <= !(br_squash_i && |(ld_br_mask_i & br_fix_mask_i));
				ent_q[tail_idx].filled <= 1'b0;
				ent_q[tail_idx].addr <= ld_addr_i;
				ent_q[tail_idx].tag <= ld_tag_i;
				ent_q[tail_idx].br_mask <= br_correct_i ? (ld_br_mask_i & ~br_fix_mask_i) :
					ld_br_mask_i;
			end
		end
	end

	assign mem.req = rd_req_q;
	assign mem.op = lsq_types_pkg::MEM_READ;
	assign mem.addr = ent_q[rd_idx_q].addr;
	assign mem.wdata = '0;

	a_no_miss_full: assert property (@(posedge clk) disable iff (rst)
		miss_i |-> !lq_full_o);

endmodule

// ==== logic/store_queue.sv ====
// Store queue holding stores from dispatch to drain, with the load age check and forwarding.
`timescale 1ns/1ps

module store_queue #(
	parameter int SQ_DEPTH = lsq_cfg_pkg::SQ_DEPTH_DEF,
	localparam int IDX_W = $clog2(SQ_DEPTH)
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           dp_st_i,
	input  logic                           st_vld_i,
	input  logic [IDX_W-1:0]               st_idx_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0] st_addr_i,
	input  logic [lsq_cfg_pkg::DATA_W-1:0] st_data_i,
	input  logic                           st_retire_i,
	input  logic                           br_squash_i,
	input  logic [IDX_W:0]                 sq_tail_restore_i,
	input  logic [IDX_W:0]                 rs_ld_pos_i,
	input  logic [IDX_W:0]                 ld_sq_pos_i,
	input  logic [lsq_cfg_pkg::ADDR_W-1:0] ld_addr_i,
	output logic                           fwd_vld_o,
	output logic [lsq_cfg_pkg::DATA_W-1:0] fwd_data_o,
	output logic                           ld_iss_ok_o,
	output logic [IDX_W:0]                 sq_tail_o,
	output logic                           sq_full_o,
	mem_req_if.requester                   mem
);

	lsq_types_pkg::sq_entry_t ent_q [SQ_DEPTH];

	logic [IDX_W:0]   head;
	logic [IDX_W:0]   rt_ptr;
	logic [IDX_W-1:0] head_idx;
	logic [IDX_W-1:0] tail_idx;
	logic             drain_req_q;

	// stores older than a load and zero once the head has passed its position
	function automatic logic [IDX_W:0] older_cnt(input logic [IDX_W:0] pos,
		input logic [IDX_W:0] hd);
		logic [IDX_W:0] diff;
		diff = pos - hd;
		return (diff > SQ_DEPTH) ? '0 : diff;
	endfunction

	// ************************************************************
	// pointers
	// ************************************************************

	ring_ptr #(
		.DEPTH(SQ_DEPTH)
	) ptr_i (
		.clk           (clk),
		.rst           (rst),
		.alloc_i       (dp_st_i),
		.free_i        (mem.done),
		.restore_i     (br_squash_i),
		.restore_ptr_i (sq_tail_restore_i),
		.head_o        (head),
		.tail_o        (sq_tail_o),
		.full_o        (sq_full_o),
		.empty_o       ()
	);

	assign head_idx = head[IDX_W-1:0];
	assign tail_idx = sq_tail_o[IDX_W-1:0];

	// retire runs ahead of the head and drain follows it one store at a time
	always_ff @(posedge clk) begin
		if (rst) begin
			rt_ptr <= '0;
			drain_req_q <= 1'b0;
		end else begin
			if (st_retire_i)
				rt_ptr <= rt_ptr + 1'b1;
			if (mem.done)
				drain_req_q <= 1'b0;
			else if (head != rt_ptr)
				drain_req_q <= 1'b1;
		end
	end

	// ************************************************************
	// entries
	// ************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < SQ_DEPTH; i++)
				ent_q[i].addr_vld <= 1'b0;
		end else begin
			if (dp_st_i)
				ent_q[tail_idx].addr_vld <= 1'b0;
			if (st_vld_i) begin
				ent_q[st_idx_i].addr_vld <= 1'b1;
				ent_q[st_idx_i].addr <= st_addr_i;
				ent_q[st_idx_i].data <= st_data_i;
			end
		end
	end

	// age check and forwarding walk the same window from the head
	always_comb begin
		logic [IDX_W:0]   iss_cnt;
		logic [IDX_W:0]   fwd_cnt;
		logic [IDX_W-1:0] idx;
		iss_cnt = older_cnt(rs_ld_pos_i, head);
		fwd_cnt = older_cnt(ld_sq_pos_i, head);
		ld_iss_ok_o = 1'b1;
		fwd_vld_o = 1'b0;
		fwd_data_o = '0;
		// oldest first so that the youngest match is the last one kept
		for (int k = 0; k < SQ_DEPTH; k++) begin
			idx = head_idx + IDX_W'(k);
			if (k < iss_cnt && !ent_q[idx].addr_vld)
				ld_iss_ok_o = 1'b0;
			if (k < fwd_cnt && ent_q[idx].addr_vld && ent_q[idx].addr == ld_addr_i) begin
				fwd_vld_o = 1'b1;
				fwd_data_o = ent_q[idx].data;
			end
		end
	end

	// head entry goes out as a whole-word write
	assign mem.req = drain_req_q;
	assign mem.op = lsq_types_pkg::MEM_WRITE;
	assign mem.addr = ent_q[head_idx].addr;
	assign mem.wdata = ent_q[head_idx].data;

	a_no_dp_full: assert property (@(posedge clk) disable iff (rst)
		dp_st_i |-> !sq_full_o);

endmodule

// ==== logic/ring_ptr.sv ====
// Head and tail ring pointers with wrap bits for a power-of-two queue, shared by both queues.
`timescale 1ns/1ps

module ring_ptr #(
	parameter int DEPTH = 4,
	localparam int IDX_W = $clog2(DEPTH)
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           alloc_i,
	input  logic           free_i,
	input  logic           restore_i,
	input  logic [IDX_W:0] restore_ptr_i,
	output logic [IDX_W:0] head_o,
	output logic [IDX_W:0] tail_o,
	output logic           full_o,
	output logic           empty_o
);

	always_ff @(posedge clk) begin
		if (rst) begin
			head_o <= '0;
			tail_o <= '0;
		end else begin
			if (free_i)
				head_o <= head_o + 1'b1;
			// branch recovery wins over a same-cycle allocation
			if (restore_i)
				tail_o <= restore_ptr_i;
			else if (alloc_i)
				tail_o <= tail_o + 1'b1;
		end
	end

	// same slot, one lap apart
	assign full_o = (head_o[IDX_W-1:0] == tail_o[IDX_W-1:0]) && (head_o[IDX_W] != tail_o[IDX_W]);
	assign empty_o = (head_o == tail_o);

endmodule

// ==== logic/mem_req_if.sv ====
// Request and completion handshake between one queue and the shared memory port controller.
`timescale 1ns/1ps

interface mem_req_if;

	// held stable by the requester from req until done
	logic                           req;
	lsq_types_pkg::mem_op_e         op;
	logic [lsq_cfg_pkg::ADDR_W-1:0] addr;
	logic [lsq_cfg_pkg::DATA_W-1:0] wdata;

	// single-cycle pulses from the controller
	logic                           grant;
	logic                           done;
	logic [lsq_cfg_pkg::DATA_W-1:0] rdata;

	modport requester (
		output req,
		output op,
		output addr,
		output wdata,
		input  grant,
		input  done,
		input  rdata
	);

	modport server (
		input  req,
		input  op,
		input  addr,
		input  wdata,
		output grant,
		output done,
		output rdata
	);

endinterface

// ==== logic/lsq_types_pkg.sv ====
// Queue entry layouts and the memory operation code used by the load-store unit.
package lsq_types_pkg;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

	// one store queue slot
	typedef struct packed {
		logic                           addr_vld;
		logic [lsq_cfg_pkg::ADDR_W-1:0] addr;
		logic [lsq_cfg_pkg::DATA_W-1:0] data;
	} sq_entry_t;

	// one load queue slot waiting on memory
	typedef struct packed {
		logic                           vld;
		logic                           filled;
		logic [lsq_cfg_pkg::ADDR_W-1:0] addr;
		logic [lsq_cfg_pkg::DATA_W-1:0] data;
		logic [lsq_cfg_pkg::TAG_W-1:0]  tag;
		logic [lsq_cfg_pkg::BR_W-1:0]   br_mask;
	} lq_entry_t;

endpackage

// ==== logic/lsq_cfg_pkg.sv ====
// Default sizes and widths of the load-store unit, referenced by every RTL block and the testbench.
package lsq_cfg_pkg;

	// word sizes
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// destination register tag
	localparam int TAG_W = 6;

	// one bit per unresolved branch
	localparam int BR_W = 4;

	// queue depths in powers of two
	localparam int SQ_DEPTH_DEF = 8;
	localparam int LQ_DEPTH_DEF = 4;

endpackage
